//--- common/cart_config.svh
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// Bus widths
`define SNES_ADDR_W    24
`define ROM_ADDR_W     23

// Pin sampling
`define SYNC_DEPTH     8   // Control pin history length
`define DATA_TAPS      5
`define ADDR_TAPS      7

// About 1 ms of CLK2 without a high console clock
`define DEAD_TIMEOUT   96000

// Countdown start of one MCU access to the PSRAM
`define ROM_CYCLE_LEN  7

`endif

//--- common/snes_bus_pkg.sv
package snes_bus_pkg;

`include "cart_config.svh"

  ////////////////////////////////////////
  // Console side of the cartridge slot
  ////////////////////////////////////////

  // Full 24 bit CPU byte address, bank in the top byte
  typedef logic [`SNES_ADDR_W-1:0] snes_addr_t;

  typedef logic [7:0] snes_byte_t;  // One data bus byte

endpackage

//--- common/rom_port_pkg.sv
package rom_port_pkg;

`include "cart_config.svh"

  typedef logic [15:0]             rom_word_t;  // Both byte lanes
  typedef logic [`ROM_ADDR_W-1:0]  rom_addr_t;  // Word address

  // Arbiter state, one bit per state
  typedef enum logic [4:0] {
    st_idle    = 5'b00001,
    st_rd_addr = 5'b00010,
    st_rd_end  = 5'b00100,
    st_wr_addr = 5'b01000,
    st_wr_end  = 5'b10000
  } rom_state_t;

  typedef logic [3:0] mem_delay_t;  // Access countdown

endpackage

//--- common/snes_strobe_if.sv
`timescale 1ns/1ps

interface snes_strobe_if;
  // Filtered pin levels
  logic read_n;
  logic write_n;
  logic cpu_clk;
  logic romsel_n;

  // Single cycle edge strobes
  logic rd_start;
  logic rd_end;
  logic wr_end;
  logic cycle_start;
  logic cycle_end;

  logic raw_clk;  // Unfiltered clock sample

  modport source (
    output read_n, write_n, cpu_clk, romsel_n,
    output rd_start, rd_end, wr_end, cycle_start, cycle_end,
    output raw_clk
  );

  modport sink (
    input read_n, write_n, cpu_clk, romsel_n,
    input rd_start, rd_end, wr_end, cycle_start, cycle_end,
    input raw_clk
  );
endinterface

//--- common/rom_grant_if.sv
`timescale 1ns/1ps

interface rom_grant_if import snes_bus_pkg::*; ();
  logic       rd_active;   // MCU read owns the ROM
  logic       wr_active;   // MCU write owns the ROM
  snes_addr_t grant_addr;  // Latched MCU byte address

  // Lane picked by address bit 0 of the current ROM address
  snes_byte_t read_byte;

  modport arbiter (
    output rd_active, wr_active, grant_addr,
    input  read_byte
  );

  modport port (
    input  rd_active, wr_active, grant_addr,
    output read_byte
  );
endinterface

//--- snes_bus/bus_delay_line.sv
`timescale 1ns/1ps

module bus_delay_line #(
  parameter type payload_t = logic [7:0],
  parameter int  TAPS      = 2
) (
  input  logic     CLK2,
  input  payload_t d,
  output payload_t q
);

  payload_t taps [TAPS];

  always_ff @(posedge CLK2) begin
    taps[0] <= d;
    for (int i = 1; i < TAPS; i++) begin
      taps[i] <= taps[i-1];
    end
  end

  // A bit only goes high once two samples agree,
  // so a single-sample spike never reaches q
  assign q = taps[TAPS-1] & taps[TAPS-2];

endmodule

//--- snes_bus/snes_bus_sampler.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module snes_bus_sampler import snes_bus_pkg::*; (
  input  logic          CLK2,
  input  logic          snes_read_n,
  input  logic          snes_write_n,
  input  logic          snes_cpu_clk,
  input  logic          snes_romsel_n,
  input  snes_addr_t    snes_addr_in,
  input  snes_byte_t    snes_data_in,
  output snes_addr_t    snes_addr,
  output snes_byte_t    snes_data,
  snes_strobe_if.source strobes
);

  logic [`SYNC_DEPTH-1:0] read_hist;
  logic [`SYNC_DEPTH-1:0] write_hist;
  logic [`SYNC_DEPTH-1:0] clk_hist;
  logic [`SYNC_DEPTH-1:0] romsel_hist;

  ////////////////////////////////////////
  // Control pin histories
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    read_hist   <= {read_hist[`SYNC_DEPTH-2:0], snes_read_n};
    write_hist  <= {write_hist[`SYNC_DEPTH-2:0], snes_write_n};
    clk_hist    <= {clk_hist[`SYNC_DEPTH-2:0], snes_cpu_clk};
    romsel_hist <= {romsel_hist[`SYNC_DEPTH-2:0], snes_romsel_n};
  end

  // Levels need two high samples in a row
  assign strobes.read_n   = read_hist[2] & read_hist[1];
  assign strobes.write_n  = write_hist[2] & write_hist[1];
  assign strobes.cpu_clk  = clk_hist[2] & clk_hist[1];
  assign strobes.romsel_n = romsel_hist[2] & romsel_hist[1];
  assign strobes.raw_clk  = clk_hist[1];

  ////////////////////////////////////////
  // Edge strobes
  ////////////////////////////////////////

  // OR of neighbours ignores a lone low, AND ignores a lone high
  assign strobes.rd_start    = ((read_hist[6:1] | read_hist[7:2]) == 6'b111100);
  assign strobes.rd_end      = ((read_hist[6:1] & read_hist[7:2]) == 6'b000001);
  assign strobes.wr_end      = ((write_hist[6:1] & write_hist[7:2]) == 6'b000001);
  assign strobes.cycle_start = ((clk_hist[7:2] & clk_hist[6:1]) == 6'b000011);  // Clock rise
  assign strobes.cycle_end   = ((clk_hist[7:2] | clk_hist[6:1]) == 6'b111000);  // Clock fall

  ////////////////////////////////////////
  // Address and data delay lines
  ////////////////////////////////////////

  bus_delay_line #(
    .payload_t (snes_addr_t),
    .TAPS      (`ADDR_TAPS)
  ) i_addr_delay (
    .CLK2 (CLK2),
    .d    (snes_addr_in),
    .q    (snes_addr)
  );

  bus_delay_line #(
    .payload_t (snes_byte_t),
    .TAPS      (`DATA_TAPS)
  ) i_data_delay (
    .CLK2 (CLK2),
    .d    (snes_data_in),
    .q    (snes_data)
  );

endmodule

//--- snes_bus/snes_liveness.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module snes_liveness (
  input  logic        CLK2,
  input  logic        reset,
  snes_strobe_if.sink strobes,
  output logic        snes_dead,
  output logic        snes_revive
);

  localparam int CNT_W = $clog2(`DEAD_TIMEOUT + 2);

  logic [CNT_W-1:0] low_cnt;  // Cycles since the clock was last high

  always_ff @(posedge CLK2) begin
    if (reset) begin
      low_cnt   <= '0;
      snes_dead <= 1'b1;  // Assume no console until its clock shows up
    end else if (strobes.raw_clk) begin
      low_cnt   <= '0;
      snes_dead <= 1'b0;
    end else begin
      if (low_cnt <= CNT_W'(`DEAD_TIMEOUT)) begin
        low_cnt <= low_cnt + 1'b1;  // Saturates just past the limit
      end
      if (low_cnt > CNT_W'(`DEAD_TIMEOUT)) begin
        snes_dead <= 1'b1;
      end
    end
  end

  // First clock after a dead period
  assign snes_revive = snes_dead & strobes.raw_clk;

endmodule

//--- mem_arb/mcu_rom_arbiter.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module mcu_rom_arbiter import snes_bus_pkg::*, rom_port_pkg::*; (
  input  logic         CLK2,
  input  logic         reset,
  input  logic         mcu_rrq,
  input  logic         mcu_wrq,
  input  snes_addr_t   mcu_addr,
  output logic         mcu_rdy,
  output snes_byte_t   mcu_din,
  input  logic         rom_hit,
  input  logic         snes_dead,
  input  logic         snes_revive,
  snes_strobe_if.sink  strobes,
  rom_grant_if.arbiter grant
);

  rom_state_t state;
  mem_delay_t mem_delay;
  logic       rd_pend;
  logic       wr_pend;
  logic       free_strobe;
  logic       free_slot;
  snes_addr_t addr_r;

  ////////////////////////////////////////
  // Request latch
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (state == st_rd_end || state == st_wr_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;  // Access done
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) begin
      addr_r <= mcu_addr;
    end
  end

  // Console cycle that does not touch ROM leaves the bus to us
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= strobes.cycle_start & ~rom_hit;
    end
  end

  assign free_slot = strobes.cycle_end | free_strobe;

  ////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state     <= st_idle;
      mem_delay <= '0;
    end else if (snes_revive) begin
      state <= st_idle;  // Console woke up mid-access, start over
    end else begin
      case (state)
        st_idle: begin
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state     <= st_rd_addr;
              mem_delay <= mem_delay_t'(`ROM_CYCLE_LEN);
            end else if (wr_pend) begin
              state     <= st_wr_addr;
              mem_delay <= mem_delay_t'(`ROM_CYCLE_LEN);
            end
          end
        end
        st_rd_addr: begin
          mem_delay <= mem_delay - 1'b1;
          if (mem_delay == '0) state <= st_rd_end;
        end
        st_wr_addr: begin
          mem_delay <= mem_delay - 1'b1;
          if (mem_delay == '0) state <= st_wr_end;
        end
        default: state <= st_idle;  // Both end states
      endcase
    end
  end

  // Last sample before rd_end is the one kept
  always_ff @(posedge CLK2) begin
    if (state == st_rd_addr) begin
      mcu_din <= grant.read_byte;
    end
  end

  assign grant.rd_active  = (state == st_rd_addr);
  assign grant.wr_active  = (state == st_wr_addr);
  assign grant.grant_addr = addr_r;

  a_busy_not_rdy: assert property (@(posedge CLK2) disable iff (reset)
    (state != st_idle) |-> !mcu_rdy);

  a_one_request: assert property (@(posedge CLK2) disable iff (reset)
    !(mcu_rrq && mcu_wrq));

endmodule

//--- mem_arb/rom_port_mux.sv
`timescale 1ns/1ps

module rom_port_mux import snes_bus_pkg::*, rom_port_pkg::*; (
  input  snes_addr_t   snes_addr,
  input  snes_addr_t   rom_mask,
  snes_strobe_if.sink  strobes,
  rom_grant_if.port    grant,
  input  snes_byte_t   mcu_dout,
  output rom_addr_t    rom_addr,
  input  rom_word_t    rom_dq_in,
  output rom_word_t    rom_dq_out,
  output logic [1:0]   rom_dq_oe,
  output logic         rom_we_n,
  output logic         rom_bhe_n,
  output logic         rom_ble_n,
  output logic         rom_hit,
  output snes_byte_t   snes_data_out,
  output logic         snes_databus_oe_n,
  output logic         snes_databus_dir
);

  snes_addr_t sel_addr;
  logic       mcu_active;
  logic       lane;  // 1 picks the low byte

  assign rom_hit    = ~strobes.romsel_n;
  assign mcu_active = grant.rd_active | grant.wr_active;
  assign sel_addr   = mcu_active ? grant.grant_addr : (snes_addr & rom_mask);

  assign rom_addr = sel_addr[$bits(snes_addr_t)-1:1];
  assign lane     = sel_addr[0];

  // Odd bytes live in the low lane
  assign rom_bhe_n = lane;
  assign rom_ble_n = ~lane;

  ////////////////////////////////////////
  // Write and read paths
  ////////////////////////////////////////

  assign rom_dq_out = {mcu_dout, mcu_dout};
  assign rom_dq_oe  = grant.wr_active ? (lane ? 2'b01 : 2'b10) : 2'b00;
  assign rom_we_n   = ~grant.wr_active;

  assign grant.read_byte = lane ? rom_dq_in[7:0] : rom_dq_in[15:8];
  assign snes_data_out   = grant.read_byte;

  assign snes_databus_dir  = ~strobes.read_n;            // 1 drives toward the console
  assign snes_databus_oe_n = ~(rom_hit & ~strobes.read_n);

endmodule

//--- src/cart_top.sv
`timescale 1ns/1ps

module cart_top import snes_bus_pkg::*, rom_port_pkg::*; (
  input  logic       CLK2,
  input  logic       reset,
  // Console bus
  input  logic       snes_read_n,
  input  logic       snes_write_n,
  input  logic       snes_cpu_clk,
  input  logic       snes_romsel_n,
  input  snes_addr_t snes_addr_in,
  input  snes_byte_t snes_data_in,
  output snes_byte_t snes_data,      // Filtered console data
  output snes_byte_t snes_data_out,
  output logic       snes_databus_oe_n,
  output logic       snes_databus_dir,
  // Microcontroller
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  snes_addr_t mcu_addr,
  input  snes_byte_t mcu_dout,
  output logic       mcu_rdy,
  output snes_byte_t mcu_din,
  input  snes_addr_t rom_mask,
  // PSRAM
  output rom_addr_t  rom_addr,
  input  rom_word_t  rom_dq_in,
  output rom_word_t  rom_dq_out,
  output logic [1:0] rom_dq_oe,
  output logic       rom_we_n,
  output logic       rom_bhe_n,
  output logic       rom_ble_n
);

  snes_addr_t snes_addr;
  logic       rom_hit;
  logic       snes_dead;
  logic       snes_revive;

  snes_strobe_if strobes ();
  rom_grant_if   grant ();

  snes_bus_sampler i_sampler (
    .CLK2          (CLK2),
    .snes_read_n   (snes_read_n),
    .snes_write_n  (snes_write_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .snes_romsel_n (snes_romsel_n),
    .snes_addr_in  (snes_addr_in),
    .snes_data_in  (snes_data_in),
    .snes_addr     (snes_addr),
    .snes_data     (snes_data),
    .strobes       (strobes.source)
  );

  snes_liveness i_liveness (
    .CLK2        (CLK2),
    .reset       (reset),
    .strobes     (strobes.sink),
    .snes_dead   (snes_dead),
    .snes_revive (snes_revive)
  );

  mcu_rom_arbiter i_arbiter (
    .CLK2        (CLK2),
    .reset       (reset),
    .mcu_rrq     (mcu_rrq),
    .mcu_wrq     (mcu_wrq),
    .mcu_addr    (mcu_addr),
    .mcu_rdy     (mcu_rdy),
    .mcu_din     (mcu_din),
    .rom_hit     (rom_hit),
    .snes_dead   (snes_dead),
    .snes_revive (snes_revive),
    .strobes     (strobes.sink),
    .grant       (grant.arbiter)
  );

  rom_port_mux i_port_mux (
    .snes_addr         (snes_addr),
    .rom_mask          (rom_mask),
    .strobes           (strobes.sink),
    .grant             (grant.port),
    .mcu_dout          (mcu_dout),
    .rom_addr          (rom_addr),
    .rom_dq_in         (rom_dq_in),
    .rom_dq_out        (rom_dq_out),
    .rom_dq_oe         (rom_dq_oe),
    .rom_we_n          (rom_we_n),
    .rom_bhe_n         (rom_bhe_n),
    .rom_ble_n         (rom_ble_n),
    .rom_hit           (rom_hit),
    .snes_data_out     (snes_data_out),
    .snes_databus_oe_n (snes_databus_oe_n),
    .snes_databus_dir  (snes_databus_dir)
  );

endmodule

//--- sim/tb_cart_top.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module tb_cart_top import snes_bus_pkg::*, rom_port_pkg::*;;

  localparam int NUM_TESTS    = 6;
  localparam int ACCESS_LIMIT = 20 * `ROM_CYCLE_LEN;
  localparam int WDOG_CYCLES  = NUM_TESTS * (`DEAD_TIMEOUT + 20 * `ROM_CYCLE_LEN);
  localparam snes_addr_t MASK = 24'h7fffff;

  logic       CLK2;
  logic       reset;
  logic       snes_read_n;
  logic       snes_write_n;
  logic       snes_cpu_clk;
  logic       snes_romsel_n;
  snes_addr_t snes_addr_in;
  snes_byte_t snes_data_in;
  snes_byte_t snes_data;
  snes_byte_t snes_data_out;
  logic       snes_databus_oe_n;
  logic       snes_databus_dir;
  logic       mcu_rrq;
  logic       mcu_wrq;
  snes_addr_t mcu_addr;
  snes_byte_t mcu_dout;
  logic       mcu_rdy;
  snes_byte_t mcu_din;
  snes_addr_t rom_mask;
  rom_addr_t  rom_addr;
  rom_word_t  rom_dq_in;
  rom_word_t  rom_dq_out;
  logic [1:0] rom_dq_oe;
  logic       rom_we_n;
  logic       rom_bhe_n;
  logic       rom_ble_n;

  int   checks;
  int   value_errors;
  int   other_errors;
  int   we_low_cycles;
  int   revive_busy;
  logic console_run;
  int   console_phase;

  cart_top i_cart_top (.*);

  ////////////////////////////////////////
  // Clock, ROM model, console clock
  ////////////////////////////////////////

  initial CLK2 = 1'b0;
  always #50 CLK2 = ~CLK2;

  // Upper byte is the word address, lower byte its inverse
  function automatic rom_word_t rom_word(input rom_addr_t waddr);
    return {waddr[7:0], ~waddr[7:0]};
  endfunction

  function automatic snes_byte_t model_byte(input snes_addr_t addr);
    rom_word_t w;
    w = rom_word(addr[23:1]);
    return addr[0] ? w[7:0] : w[15:8];
  endfunction

  assign rom_dq_in = rom_word(rom_addr);

  // 6 cycles high, 6 low; the first running cycle goes high
  initial snes_cpu_clk = 1'b0;
  always @(posedge CLK2) begin
    logic run_now;
    run_now = console_run;  // Taken at the edge, changed only at +10
    #10;
    if (run_now) begin
      snes_cpu_clk  = (console_phase < 6);
      console_phase = (console_phase + 1) % 12;
    end else begin
      snes_cpu_clk  = 1'b0;
      console_phase = 0;
    end
  end

  always @(negedge CLK2) begin
    if (!reset && !rom_we_n) we_low_cycles++;
    if (!reset && i_cart_top.snes_revive && !mcu_rdy) revive_busy++;
  end

  ////////////////////////////////////////
  // Write port checks
  ////////////////////////////////////////

  a_wr_addr: assert property (@(posedge CLK2) disable iff (reset)
    !rom_we_n |-> rom_addr == mcu_addr[23:1])
    else begin
      value_errors++;
      $display("** Error: rom_addr = 0x%h, expected 0x%h", $sampled(rom_addr),
               $sampled(mcu_addr[23:1]));
    end

  a_wr_lane: assert property (@(posedge CLK2) disable iff (reset)
    !rom_we_n |-> (mcu_addr[0] ? (rom_dq_oe[0] && rom_dq_out[7:0] == mcu_dout)
                              : (rom_dq_oe[1] && rom_dq_out[15:8] == mcu_dout)))
    else begin
      value_errors++;
      $display("** Error: rom_dq_out = 0x%h, rom_dq_oe = 0x%h, expected byte 0x%h",
               $sampled(rom_dq_out), $sampled(rom_dq_oe), $sampled(mcu_dout));
    end

  a_wr_bytesel: assert property (@(posedge CLK2) disable iff (reset)
    !rom_we_n |-> (rom_bhe_n == mcu_addr[0] && rom_ble_n == !mcu_addr[0]))
    else begin
      value_errors++;
      $display("** Error: rom_bhe_n/rom_ble_n = 0x%h/0x%h, address bit 0 = 0x%h",
               $sampled(rom_bhe_n), $sampled(rom_ble_n), $sampled(mcu_addr[0]));
    end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic expect_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    checks++;
    a_value: assert (actual === expected)
      else begin
        value_errors++;
        $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    a_cond: assert (cond)
      else begin
        other_errors++;
        $display("%s at %0t", what, $time);
      end
  endtask

  // Pulses one request and returns once it has been taken
  task automatic start_access(input logic is_write, input snes_addr_t addr,
                              input snes_byte_t data);
    @(posedge CLK2);
    #10;
    mcu_addr = addr;
    mcu_dout = data;
    mcu_rrq  = !is_write;
    mcu_wrq  = is_write;
    @(posedge CLK2);
    #10;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
  endtask

  // Cycles counts the clock periods until mcu_rdy is seen high again
  task automatic wait_ready(output int cycles);
    cycles = 0;
    @(negedge CLK2);
    expect_value("mcu_rdy", mcu_rdy, 0);
    while (!mcu_rdy && cycles < ACCESS_LIMIT) begin
      @(negedge CLK2);
      cycles++;
    end
    expect_true(mcu_rdy, "MCU access did not finish in time");
  endtask

  task automatic print_counts();
    $display("Checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    snes_addr_t addr;
    snes_byte_t data;
    int         we_before;
    int         latency;
    checks = 0;
    value_errors = 0;
    other_errors = 0;
    we_low_cycles = 0;
    revive_busy = 0;
    console_run = 1'b0;
    console_phase = 0;
    reset = 1'b1;
    snes_read_n = 1'b1;
    snes_write_n = 1'b1;
    snes_romsel_n = 1'b1;
    snes_addr_in = '0;
    snes_data_in = '0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_dout = '0;
    rom_mask = MASK;
    void'($urandom(32'ha648));
    repeat (5) @(posedge CLK2);
    #10 reset = 1'b0;

    // Idle outputs after reset
    @(negedge CLK2);
    expect_value("mcu_rdy", mcu_rdy, 1);
    expect_value("rom_we_n", rom_we_n, 1);
    expect_value("rom_dq_oe", rom_dq_oe, 0);
    expect_value("snes_databus_oe_n", snes_databus_oe_n, 1);

    // Reads with the console dead
    for (int i = 0; i < 4; i++) begin
      addr = {23'($urandom()), 1'b0} | snes_addr_t'(i % 2);
      start_access(1'b0, addr, 8'h00);
      wait_ready(latency);
      expect_value("mcu_din", mcu_din, model_byte(addr));
    end

    // Writes with the console dead
    for (int i = 0; i < 4; i++) begin
      addr = {23'($urandom()), 1'b0} | snes_addr_t'(i % 2);
      data = 8'($urandom());
      we_before = we_low_cycles;
      start_access(1'b1, addr, data);
      wait_ready(latency);
      expect_true(we_low_cycles > we_before, "rom_we_n never went low during a write");
    end

    // Console clock starts while a read is in progress
    addr = {23'($urandom()), 1'b1};
    start_access(1'b0, addr, 8'h00);
    console_run = 1'b1;
    wait_ready(latency);
    expect_value("mcu_din", mcu_din, model_byte(addr));
    expect_true(revive_busy > 0, "console clock start did not restart the pending read");
    // An undisturbed access is ready ROM_CYCLE_LEN + 3 cycles after the request
    expect_true(latency > `ROM_CYCLE_LEN + 3,
                "read finished without starting over when the console clock began");

    // Console ROM read with no MCU access, bit 23 set so the mask matters
    @(posedge CLK2);
    #10;
    addr = {1'b1, 23'($urandom())};
    data = 8'($urandom());
    snes_addr_in  = addr;
    snes_data_in  = data;
    snes_read_n   = 1'b0;
    snes_romsel_n = 1'b0;
    repeat (12) @(posedge CLK2);
    @(negedge CLK2);
    expect_value("rom_addr", rom_addr, (addr & MASK) >> 1);
    expect_value("snes_data_out", snes_data_out, model_byte(addr & MASK));
    expect_value("snes_data", snes_data, data);
    expect_value("snes_databus_dir", snes_databus_dir, 1);
    expect_value("snes_databus_oe_n", snes_databus_oe_n, 0);

    // MCU reads while the console keeps reading ROM
    for (int i = 0; i < 3; i++) begin
      addr = {23'($urandom()), 1'b0} | snes_addr_t'(i % 2);
      start_access(1'b0, addr, 8'h00);
      wait_ready(latency);
      expect_value("mcu_din", mcu_din, model_byte(addr));
    end

    repeat (4) @(posedge CLK2);
    print_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge CLK2);
    $display("Watchdog expired before the tests finished");
    print_counts();
    $display("Regression failed");
    $finish;
  end

endmodule

//--- list.f
+incdir+common
common/snes_bus_pkg.sv
common/rom_port_pkg.sv
common/snes_strobe_if.sv
common/rom_grant_if.sv
snes_bus/bus_delay_line.sv
snes_bus/snes_bus_sampler.sv
snes_bus/snes_liveness.sv
mem_arb/mcu_rom_arbiter.sv
mem_arb/rom_port_mux.sv
src/cart_top.sv
sim/tb_cart_top.sv
